//--- aprPkg.sv
`default_nettype none

package aprPkg;

  localparam int wordW = 36;
  localparam int nEvents = 8;
  localparam int blockW = 3;
  localparam int acW = 4;
  localparam int magicW = 9;

  // Event source bit positions
  localparam int evSbusErr = 0;
  localparam int evNxmErr = 1;
  localparam int evIoPageFail = 2;
  localparam int evMbParErr = 3;
  localparam int evCacheDirParErr = 4;
  localparam int evSbusAdrParErr = 5;
  localparam int evPwrFail = 6;
  localparam int evSweepDone = 7;

  // Fast-memory address source select
  localparam logic [2:0] fmAc = 3'd0;
  localparam logic [2:0] fmAcPlus1 = 3'd1;
  localparam logic [2:0] fmXr = 3'd2;
  localparam logic [2:0] fmVma = 3'd3;
  localparam logic [2:0] fmAcPlus2 = 3'd4;
  localparam logic [2:0] fmAcPlus3 = 3'd5;
  localparam logic [2:0] fmAcMagic = 3'd6;
  localparam logic [2:0] fmMagic = 3'd7;

  // Diagnostic read select, codes 5 to 7 read zero
  localparam logic [2:0] rdFlags = 3'd0;
  localparam logic [2:0] rdEnables = 3'd1;
  localparam logic [2:0] rdBlocks = 3'd2;
  localparam logic [2:0] rdFmAddr = 3'd3;
  localparam logic [2:0] rdIntState = 3'd4;

  // APR condition-out word
  typedef struct packed {
    logic [11:0] unusedHi;
    logic        selEn;
    logic        selDis;
    logic        selClr;
    logic        selSet;
    logic [7:0]  eventMask;
    logic [7:0]  unusedMid;
    logic        loadPia;
    logic [2:0]  pia;
  } conoViewT;

  // AC block load word
  typedef struct packed {
    logic [5:0]  unusedHi;
    logic [2:0]  curBlock;
    logic [2:0]  prevBlock;
    logic [23:0] unusedLo;
  } blockViewT;

  typedef union packed {
    conoViewT  conoView;
    blockViewT blockView;
  } aprBusWord;

endpackage

`default_nettype wire

//--- aprEvents.sv
`timescale 1ns/1ps
`default_nettype none

module aprEvents import aprPkg::*; (
  input  logic               clk,
  input  logic               arstN,
  input  logic               conoApr,
  input  aprBusWord          busData,
  input  logic [nEvents-1:0] eventIn,
  input  logic               sweepBusy,
  output logic [nEvents-1:0] flags,
  output logic [nEvents-1:0] enables,
  output logic               aprInt,
  output logic [2:0]         piaLevel,
  output logic               anyEboxErr
);

  logic [nEvents-1:0] eventPulse;
  logic [nEvents-1:0] setMask;
  logic [nEvents-1:0] clrMask;
  logic [nEvents-1:0] enMask;
  logic [nEvents-1:0] disMask;
  logic               sweepPrev;
  logic               sweepFall;

  // Falling edge of sweepBusy, registered once more before it hits the flag
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      sweepPrev <= 1'b0;
      sweepFall <= 1'b0;
    end else begin
      sweepPrev <= sweepBusy;
      sweepFall <= sweepPrev & ~sweepBusy;
    end
  end

  always_comb begin
    eventPulse = eventIn;
    eventPulse[evSweepDone] = eventIn[evSweepDone] | sweepFall;
  end

  // Per-source CONO strobes
  assign setMask = (conoApr && busData.conoView.selSet) ? busData.conoView.eventMask : '0;
  assign clrMask = (conoApr && busData.conoView.selClr) ? busData.conoView.eventMask : '0;
  assign enMask = (conoApr && busData.conoView.selEn) ? busData.conoView.eventMask : '0;
  assign disMask = (conoApr && busData.conoView.selDis) ? busData.conoView.eventMask : '0;

  // Set and pulses override clear, enable overrides disable
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= '0;
      enables <= '0;
      piaLevel <= '0;
    end else begin
      flags <= eventPulse | setMask | (flags & ~clrMask);
      enables <= enMask | (enables & ~disMask);
      if (conoApr && busData.conoView.loadPia) begin
        piaLevel <= busData.conoView.pia;
      end
    end
  end

  assign aprInt = |(flags & enables);

  // Errors the EBOX itself has to see
  assign anyEboxErr = flags[evNxmErr] | flags[evMbParErr] | flags[evSbusAdrParErr];

endmodule

`default_nettype wire

//--- acBlocks.sv
`timescale 1ns/1ps
`default_nettype none

module acBlocks import aprPkg::*; (
  input  logic              clk,
  input  logic              arstN,
  input  aprBusWord         busData,
  input  logic              loadBlocks,
  input  logic              loadVmaContext,
  input  logic              vmaPrevEn,
  input  logic              xrPrevious,
  output logic [blockW-1:0] currentBlock,
  output logic [blockW-1:0] prevBlock,
  output logic [blockW-1:0] vmaBlock,
  output logic [blockW-1:0] xrBlock
);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      currentBlock <= '0;
      prevBlock <= '0;
    end else if (loadBlocks) begin
      currentBlock <= busData.blockView.curBlock;
      prevBlock <= busData.blockView.prevBlock;
    end
  end

  // Block used by virtual memory references
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      vmaBlock <= '0;
    end else if (loadVmaContext) begin
      vmaBlock <= vmaPrevEn ? prevBlock : currentBlock;
    end
  end

  // Index register fetch may come from the previous context
  assign xrBlock = xrPrevious ? prevBlock : currentBlock;

endmodule

`default_nettype wire

//--- fmAddrGen.sv
`timescale 1ns/1ps
`default_nettype none

module fmAddrGen import aprPkg::*; (
  input  logic [2:0]            fmSel,
  input  logic [acW-1:0]        ac,
  input  logic [acW-1:0]        xr,
  input  logic [acW-1:0]        vmaLow,
  input  logic [magicW-1:0]     magic,
  input  logic [blockW-1:0]     currentBlock,
  input  logic [blockW-1:0]     xrBlock,
  input  logic [blockW-1:0]     vmaBlock,
  output logic [blockW+acW-1:0] fmAddr
);

  logic [acW-1:0]    acPlus1;
  logic [acW-1:0]    acPlus2;
  logic [acW-1:0]    acPlus3;
  logic [acW-1:0]    acPlusMagic;
  logic [blockW-1:0] fmBlock;
  logic [acW-1:0]    fmAdr;

  // All AC arithmetic wraps within the 16-word block
  assign acPlus1 = ac + acW'(1);
  assign acPlus2 = ac + acW'(2);
  assign acPlus3 = ac + acW'(3);
  assign acPlusMagic = ac + magic[acW-1:0];

  always_comb begin
    fmBlock = currentBlock;
    fmAdr = ac;
    case (fmSel)
      fmAc: fmAdr = ac;
      fmAcPlus1: fmAdr = acPlus1;
      fmAcPlus2: fmAdr = acPlus2;
      fmAcPlus3: fmAdr = acPlus3;
      fmAcMagic: fmAdr = acPlusMagic;
      fmXr: begin
        fmBlock = xrBlock;
        fmAdr = xr;
      end
      fmVma: begin
        fmBlock = vmaBlock;
        fmAdr = vmaLow;
      end
      fmMagic: begin
        // Absolute block and address straight from microcode
        fmBlock = magic[acW+blockW-1:acW];
        fmAdr = magic[acW-1:0];
      end
      default: fmAdr = ac;
    endcase
  end

  assign fmAddr = {fmBlock, fmAdr};

endmodule

`default_nettype wire

//--- diagReadMux.sv
`timescale 1ns/1ps
`default_nettype none

module diagReadMux import aprPkg::*; (
  input  logic                  diagRead,
  input  logic [2:0]            diagSel,
  input  logic [nEvents-1:0]    flags,
  input  logic [nEvents-1:0]    enables,
  input  logic [blockW-1:0]     currentBlock,
  input  logic [blockW-1:0]     prevBlock,
  input  logic [blockW-1:0]     vmaBlock,
  input  logic [blockW+acW-1:0] fmAddr,
  input  logic                  aprInt,
  input  logic                  anyEboxErr,
  input  logic [2:0]            piaLevel,
  output logic [wordW-1:0]      readData
);

  // Fields are right-justified on the bus
  always_comb begin
    readData = '0;
    if (diagRead) begin
      case (diagSel)
        rdFlags: begin
          readData = wordW'(flags);
        end
        rdEnables: begin
          readData = wordW'(enables);
        end
        rdBlocks: begin
          readData = wordW'({currentBlock, prevBlock, vmaBlock});
        end
        rdFmAddr: begin
          readData = wordW'(fmAddr);
        end
        rdIntState: begin
          readData = wordW'({aprInt, anyEboxErr, piaLevel});
        end
        default: begin
          readData = '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- apr.sv
`timescale 1ns/1ps
`default_nettype none

module apr import aprPkg::*; (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic [wordW-1:0]      busData,
  input  logic                  conoApr,
  input  logic                  loadBlocks,
  input  logic                  loadVmaContext,
  input  logic                  vmaPrevEn,
  input  logic                  xrPrevious,
  input  logic                  sbusErr,
  input  logic                  nxmErr,
  input  logic                  ioPageFail,
  input  logic                  mbParErr,
  input  logic                  cacheDirParErr,
  input  logic                  sbusAdrParErr,
  input  logic                  pwrWarn,
  input  logic                  sweepBusy,
  input  logic [acW-1:0]        ac,
  input  logic [acW-1:0]        xr,
  input  logic [acW-1:0]        vmaLow,
  input  logic [magicW-1:0]     magic,
  input  logic [2:0]            fmSel,
  input  logic                  diagRead,
  input  logic [2:0]            diagSel,
  output logic                  aprInt,
  output logic [2:0]            piaLevel,
  output logic                  anyEboxErr,
  output logic [blockW+acW-1:0] fmAddr,
  output logic [wordW-1:0]      readData
);

  logic [nEvents-1:0] eventIn;
  logic [nEvents-1:0] flags;
  logic [nEvents-1:0] enables;
  logic [blockW-1:0]  currentBlock;
  logic [blockW-1:0]  prevBlock;
  logic [blockW-1:0]  vmaBlock;
  logic [blockW-1:0]  xrBlock;

  always_comb begin
    eventIn = '0;
    eventIn[evSbusErr] = sbusErr;
    eventIn[evNxmErr] = nxmErr;
    eventIn[evIoPageFail] = ioPageFail;
    eventIn[evMbParErr] = mbParErr;
    eventIn[evCacheDirParErr] = cacheDirParErr;
    eventIn[evSbusAdrParErr] = sbusAdrParErr;
    eventIn[evPwrFail] = pwrWarn;
    // Sweep done comes from the sweepBusy edge inside aprEvents
    eventIn[evSweepDone] = 1'b0;
  end

  aprEvents events (
    .clk(clk), .arstN(arstN), .conoApr(conoApr), .busData(busData),
    .eventIn(eventIn), .sweepBusy(sweepBusy), .flags(flags), .enables(enables),
    .aprInt(aprInt), .piaLevel(piaLevel), .anyEboxErr(anyEboxErr)
  );

  acBlocks blocks (
    .clk(clk), .arstN(arstN), .busData(busData), .loadBlocks(loadBlocks),
    .loadVmaContext(loadVmaContext), .vmaPrevEn(vmaPrevEn), .xrPrevious(xrPrevious),
    .currentBlock(currentBlock), .prevBlock(prevBlock), .vmaBlock(vmaBlock),
    .xrBlock(xrBlock)
  );

  fmAddrGen addrGen (
    .fmSel(fmSel), .ac(ac), .xr(xr), .vmaLow(vmaLow), .magic(magic),
    .currentBlock(currentBlock), .xrBlock(xrBlock), .vmaBlock(vmaBlock),
    .fmAddr(fmAddr)
  );

  diagReadMux readMux (
    .diagRead(diagRead), .diagSel(diagSel), .flags(flags), .enables(enables),
    .currentBlock(currentBlock), .prevBlock(prevBlock), .vmaBlock(vmaBlock),
    .fmAddr(fmAddr), .aprInt(aprInt), .anyEboxErr(anyEboxErr),
    .piaLevel(piaLevel), .readData(readData)
  );

endmodule

`default_nettype wire

//--- aprProps_chk.sv
`timescale 1ns/1ps
`default_nettype none

module aprProps import aprPkg::*; (
  input logic               clk,
  input logic               arstN,
  input logic               diagRead,
  input logic [wordW-1:0]   readData,
  input logic               aprInt,
  input logic               pwrWarn,
  input logic [nEvents-1:0] flags,
  input logic [nEvents-1:0] enables
);

  int failCount = 0;

  // Read bus idles at zero
  assert property (@(posedge clk) disable iff (!arstN) !diagRead |-> readData == '0)
    else begin
      failCount++;
      $error("readData is not zero while diagRead is low");
    end

  assert property (@(posedge clk) disable iff (!arstN) aprInt == |(flags & enables))
    else begin
      failCount++;
      $error("aprInt does not match the enabled flags");
    end

  assert property (@(posedge clk) disable iff (!arstN) pwrWarn |=> flags[evPwrFail])
    else begin
      failCount++;
      $error("power-fail flag not set after pwrWarn");
    end

  // First edge out of reset
  assert property (@(posedge clk) $rose(arstN) |-> flags == '0)
    else begin
      failCount++;
      $error("flags not clear after reset release");
    end

endmodule

`default_nettype wire

//--- aprTb.sv
`timescale 1ns/1ps
`default_nettype none

module aprTb
  import aprPkg::*;
();

  logic                  clk = 1'b0;
  logic                  arstN;
  logic [wordW-1:0]      busData;
  logic                  conoApr;
  logic                  loadBlocks;
  logic                  loadVmaContext;
  logic                  vmaPrevEn;
  logic                  xrPrevious;
  logic                  sbusErr;
  logic                  nxmErr;
  logic                  ioPageFail;
  logic                  mbParErr;
  logic                  cacheDirParErr;
  logic                  sbusAdrParErr;
  logic                  pwrWarn;
  logic                  sweepBusy;
  logic [acW-1:0]        ac;
  logic [acW-1:0]        xr;
  logic [acW-1:0]        vmaLow;
  logic [magicW-1:0]     magic;
  logic [2:0]            fmSel;
  logic                  diagRead;
  logic [2:0]            diagSel;
  logic                  aprInt;
  logic [2:0]            piaLevel;
  logic                  anyEboxErr;
  logic [blockW+acW-1:0] fmAddr;
  logic [wordW-1:0]      readData;

  string caseLines[$];
  int    nTests = 0;
  int    nPass = 0;
  int    nFail = 0;
  int    cycles = 0;
  int    cycleLimit = 100;
  int    seed;

  apr dut (.*);

  bind apr aprProps props (
    .clk(clk), .arstN(arstN), .diagRead(diagRead), .readData(readData),
    .aprInt(aprInt), .pwrWarn(pwrWarn), .flags(flags), .enables(enables)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycleLimit) begin
      $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic nextDriveSlot();
    @(posedge clk);
    #1;
  endtask

  task automatic checkValue(input string name, input logic [wordW-1:0] expVal,
                            input logic [wordW-1:0] actual);
    nTests++;
    assert (actual === expVal) begin
      nPass++;
      $display("ok      %s", name);
    end else begin
      nFail++;
      $display("[ERROR] %s expected %h actual %h", name, expVal, actual);
    end
  endtask

  task automatic readCheck(input string name, input logic [2:0] sel,
                           input logic [wordW-1:0] expVal);
    diagRead = 1'b1;
    diagSel = sel;
    #2;
    checkValue(name, expVal, readData);
    // Interrupt state is also visible on the top-level pins
    if (sel == rdIntState) begin
      checkValue({name, "Pins"}, expVal, wordW'({aprInt, anyEboxErr, piaLevel}));
    end
    nextDriveSlot();
  endtask

  task automatic driveEvents(input logic [nEvents-1:0] ev);
    sbusErr = ev[evSbusErr];
    nxmErr = ev[evNxmErr];
    ioPageFail = ev[evIoPageFail];
    mbParErr = ev[evMbParErr];
    cacheDirParErr = ev[evCacheDirParErr];
    sbusAdrParErr = ev[evSbusAdrParErr];
    pwrWarn = ev[evPwrFail];
  endtask

  task automatic loadCases();
    int    fd;
    string line;
    fd = $fopen("aprCases.txt", "r");
    if (fd == 0) begin
      nFail++;
      $display("Cannot open aprCases.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Skip comment and blank lines
        if (line.len() > 1 && line[0] != "#") begin
          caseLines.push_back(line);
        end
      end
      $fclose(fd);
      if (caseLines.size() == 0) begin
        nFail++;
        $display("The cases file holds no test lines");
      end
    end
  endtask

  task automatic runCase(input string line);
    string            op;
    string            name;
    logic [wordW-1:0] argA;
    logic [wordW-1:0] argB;
    logic [wordW-1:0] argC;
    logic [wordW-1:0] argD;
    logic [wordW-1:0] argE;
    logic [wordW-1:0] expVal;
    if ($sscanf(line, "%s %s %h %h %h %h %h %h", op, name, argA, argB, argC, argD,
                argE, expVal) != 8) begin
      nFail++;
      $display("A line of the cases file could not be parsed: %s", line);
    end else begin
      case (op)
        "W": begin
          busData = argA;
          conoApr = 1'b1;
          nextDriveSlot();
          conoApr = 1'b0;
          readCheck(name, argB[2:0], expVal);
        end
        "P": begin
          driveEvents(argA[nEvents-1:0]);
          busData = argB;
          conoApr = (argB != '0);
          nextDriveSlot();
          driveEvents('0);
          conoApr = 1'b0;
          readCheck(name, argC[2:0], expVal);
        end
        "S": begin
          sweepBusy = argA[0];
          repeat (argB) @(posedge clk);
          #1;
          readCheck(name, argC[2:0], expVal);
        end
        "B": begin
          busData = argA;
          loadBlocks = 1'b1;
          nextDriveSlot();
          loadBlocks = 1'b0;
          readCheck(name, argB[2:0], expVal);
        end
        "V": begin
          vmaPrevEn = argA[0];
          xrPrevious = argB[0];
          loadVmaContext = 1'b1;
          nextDriveSlot();
          loadVmaContext = 1'b0;
          readCheck(name, argC[2:0], expVal);
        end
        "A": begin
          fmSel = argA[2:0];
          ac = argB[acW-1:0];
          xr = argC[acW-1:0];
          vmaLow = argD[acW-1:0];
          magic = argE[magicW-1:0];
          #2;
          checkValue(name, expVal, wordW'(fmAddr));
          nextDriveSlot();
        end
        "R": begin
          diagRead = argA[0];
          diagSel = argB[2:0];
          #2;
          checkValue(name, expVal, readData);
          if (diagRead && diagSel == rdIntState) begin
            checkValue({name, "Pins"}, expVal, wordW'({aprInt, anyEboxErr, piaLevel}));
          end
          nextDriveSlot();
        end
        default: begin
          nFail++;
          $display("Case %s has an unknown operation %s", name, op);
        end
      endcase
    end
  endtask

  task automatic randomAddrChecks();
    aprBusWord  w;
    logic [3:0] acVal;
    logic [3:0] offset;
    logic [3:0] sum;
    logic [8:0] magicVal;
    int         pick;
    // Known current block for the expected addresses
    w = '0;
    w.blockView.curBlock = 3'd5;
    w.blockView.prevBlock = 3'd1;
    busData = w;
    loadBlocks = 1'b1;
    nextDriveSlot();
    loadBlocks = 1'b0;
    for (int i = 0; i < 20; i++) begin
      acVal = 4'($random(seed));
      magicVal = 9'($random(seed));
      pick = $random(seed) & 3;
      case (pick)
        0: begin
          fmSel = fmAcPlus1;
          offset = 4'd1;
        end
        1: begin
          fmSel = fmAcPlus2;
          offset = 4'd2;
        end
        2: begin
          fmSel = fmAcPlus3;
          offset = 4'd3;
        end
        default: begin
          fmSel = fmAcMagic;
          offset = magicVal[3:0];
        end
      endcase
      ac = acVal;
      magic = magicVal;
      // Modulo 16 within the block
      sum = acVal + offset;
      #2;
      checkValue($sformatf("randAddr%0d", i), wordW'({3'd5, sum}), wordW'(fmAddr));
      nextDriveSlot();
    end
  endtask

  initial begin
    seed = 16;
    arstN = 1'b0;
    busData = '0;
    conoApr = 1'b0;
    loadBlocks = 1'b0;
    loadVmaContext = 1'b0;
    vmaPrevEn = 1'b0;
    xrPrevious = 1'b0;
    driveEvents('0);
    sweepBusy = 1'b0;
    ac = '0;
    xr = '0;
    vmaLow = '0;
    magic = '0;
    fmSel = fmAc;
    diagRead = 1'b0;
    diagSel = rdFlags;
    loadCases();
    cycleLimit = 4 * caseLines.size() + 100;
    repeat (3) @(posedge clk);
    #1;
    arstN = 1'b1;
    foreach (caseLines[i]) begin
      runCase(caseLines[i]);
    end
    randomAddrChecks();
    $display("Tests %0d, passed %0d, failed %0d, assertion failures %0d",
             nTests, nPass, nFail, dut.props.failCount);
    if (nFail == 0 && dut.props.failCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- aprCases.txt
# op name argA argB argC argD argE expected, all hex
# W word sel | P events word sel | S level waitEdges sel | B word sel | V vmaPrevEn xrPrevious sel | A fmSel ac xr vmaLow magic | R diagRead sel
R rstFlags 1 0 0 0 0 0
R rstEnables 1 1 0 0 0 0
R rstBlocks 1 2 0 0 0 0
R rstIntState 1 4 0 0 0 0
P pulseNxm 02 0 4 0 0 8
W enableNxm 802000 4 0 0 0 18
P pulseIoPf 04 0 0 0 0 06
W setClrSame 330000 0 0 0 0 36
W clearIoPf 204000 0 0 0 0 32
P pulseWithClr 01 211000 0 0 0 23
W enDisSame cc0000 1 0 0 0 c2
W disableNxm 402000 4 0 0 0 08
P pulsePwr 40 0 4 0 0 18
W clearErrs 222000 4 0 0 0 10
W loadPia 00000d 4 0 0 0 15
S sweepHigh 1 1 0 0 0 41
S sweepDrop 0 2 0 0 0 c1
B loadBlocks 33000000 2 0 0 0 198
V vmaCurrent 0 0 2 0 0 19e
A addrXrCur 2 0 9 0 0 69
V vmaPrevious 1 1 2 0 0 19b
A addrXrPrev 2 0 9 0 0 39
A addrAc 0 7 0 0 0 67
A addrPlus1Wrap 1 f 0 0 0 60
A addrPlus2 4 d 0 0 0 6f
A addrPlus3Wrap 5 f 0 0 0 62
A addrAcMagic 6 a 0 0 1f7 61
A addrVma 3 0 0 4 0 34
A addrMagic 7 0 0 0 1db 5b
R readFmAddr 1 3 0 0 0 5b
R offIntState 0 4 0 0 0 0
R readCode5 1 5 0 0 0 0

//--- files.f
aprPkg.sv
aprEvents.sv
acBlocks.sv
fmAddrGen.sv
diagReadMux.sv
apr.sv
aprProps_chk.sv
aprTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the APR testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --top-module aprTb -f files.f -o aprSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep running past bound assertion errors so the testbench reports them
./obj_dir/aprSim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
  exit 0
else
  exit 1
fi
